// File: common/rv32_isa_pkg.sv
package rv32_isa_pkg;

  typedef enum logic [6:0] {
    OPC_HALT   = 7'b0000000,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  localparam int unsigned OPC_LSB = 0;
  localparam int unsigned RD_LSB  = 7;
  localparam int unsigned F3_LSB  = 12;
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned ALT_BIT = 30; // sub / sra select

  // OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'd0;
  localparam logic [2:0] F3_SLL  = 3'd1;
  localparam logic [2:0] F3_SLT  = 3'd2;
  localparam logic [2:0] F3_SLTU = 3'd3;
  localparam logic [2:0] F3_XOR  = 3'd4;
  localparam logic [2:0] F3_SR   = 3'd5;
  localparam logic [2:0] F3_OR   = 3'd6;
  localparam logic [2:0] F3_AND  = 3'd7;

  localparam logic [2:0] F3_BEQ  = 3'd0;
  localparam logic [2:0] F3_BNE  = 3'd1;
  localparam logic [2:0] F3_BLT  = 3'd4;
  localparam logic [2:0] F3_BGE  = 3'd5;
  localparam logic [2:0] F3_BLTU = 3'd6;
  localparam logic [2:0] F3_BGEU = 3'd7;

  localparam logic [2:0] F3_LW   = 3'd2;
  localparam logic [2:0] F3_LBU  = 3'd4;
  localparam logic [2:0] F3_LHU  = 3'd5;
  localparam logic [2:0] F3_SB   = 3'd0;
  localparam logic [2:0] F3_SH   = 3'd1;
  localparam logic [2:0] F3_SW   = 3'd2;

  localparam logic [1:0] FLAG_ZERO = 2'd0; // temp bits after a subtract
  localparam logic [1:0] FLAG_LT   = 2'd1;
  localparam logic [1:0] FLAG_LTU  = 2'd2;

  typedef logic [1:0] step_t;

endpackage

// File: common/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  typedef enum logic [1:0] {
    PC_NEXT = 2'd0,
    PC_INIT = 2'd1, // init address
    PC_ALU  = 2'd3  // also routes the memory address
  } pc_sel_t;

  typedef enum logic [1:0] {
    A_RS1 = 2'd0,
    A_PC  = 2'd1
  } opnd_a_t;

  typedef enum logic [1:0] {
    B_RS2  = 2'd0,
    B_IMM  = 2'd1,
    B_TEMP = 2'd2
  } opnd_b_t;

  typedef enum logic [2:0] {
    WD_ALU  = 3'd0,
    WD_MEM  = 3'd1,
    WD_ALU4 = 3'd2,
    WD_TEMP = 3'd3,
    WD_LT   = 3'd4,
    WD_LTU  = 3'd5
  } wd_sel_t;

  typedef enum logic [2:0] {
    FMT_I = 3'd0,
    FMT_S = 3'd1,
    FMT_B = 3'd2,
    FMT_U = 3'd3,
    FMT_J = 3'd4
  } imm_fmt_t;

  // {cin, arith, sel[3:0]}
  typedef enum logic [5:0] {
    ALU_ADD    = 6'b01_0000,
    ALU_SUB    = 6'b01_0011,
    ALU_PASS_B = 6'b00_0011,
    ALU_SLL    = 6'b01_0110,
    ALU_SRL    = 6'b01_0100,
    ALU_SRA    = 6'b11_0100,
    ALU_OR     = 6'b00_0100,
    ALU_AND    = 6'b00_1000,
    ALU_XOR    = 6'b00_1100,
    ALU_ONES   = 6'b01_1111  // all-ones mask
  } alu_op_t;

  typedef enum logic [2:0] {
    MEM_RB = 3'b000,
    MEM_RH = 3'b001,
    MEM_RW = 3'b010,
    MEM_WB = 3'b100,
    MEM_WH = 3'b101,
    MEM_WW = 3'b110
  } mem_cmd_t;

  typedef struct packed {
    logic       rf_we;
    logic       rf_pc_we;
    logic       temp_we;
    logic       temp_sel;
    logic       memctrl_en;
    pc_sel_t    pc_sel;
    opnd_a_t    a_sel;
    opnd_b_t    b_sel;
    wd_sel_t    wd_sel;
    imm_fmt_t   format;
    alu_op_t    alu_op;
    mem_cmd_t   mem_cmd;
    logic [4:0] ra1;
    logic [4:0] ra2;
    logic [4:0] wa;
  } ctrl_t;

  localparam ctrl_t CTRL_IDLE = '{
    rf_we:      1'b0,
    rf_pc_we:   1'b0,
    temp_we:    1'b0,
    temp_sel:   1'b0,
    memctrl_en: 1'b0,
    pc_sel:     PC_NEXT,
    a_sel:      A_RS1,
    b_sel:      B_RS2,
    wd_sel:     WD_ALU,
    format:     FMT_I,
    alu_op:     ALU_ADD,
    mem_cmd:    MEM_RW,
    ra1:        5'd0,
    ra2:        5'd0,
    wa:         5'd0
  };

  // idle word with register addresses from the instruction
  function automatic ctrl_t idle_word(input logic [31:0] instr);
    ctrl_t c;
    c     = CTRL_IDLE;
    c.ra1 = instr[rv32_isa_pkg::RS1_LSB +: 5];
    c.ra2 = instr[rv32_isa_pkg::RS2_LSB +: 5];
    c.wa  = instr[rv32_isa_pkg::RD_LSB +: 5];
    return c;
  endfunction

  // pc update plus next fetch request
  function automatic ctrl_t with_fetch(input ctrl_t c);
    ctrl_t r;
    r            = c;
    r.rf_pc_we   = 1'b1;
    r.memctrl_en = 1'b1;
    r.mem_cmd    = MEM_RW;
    return r;
  endfunction

endpackage

// File: common/exec_if.sv
interface exec_if;

  logic                 valid;
  rv32_isa_pkg::step_t  step;
  logic                 claim;
  cpu_ctrl_pkg::ctrl_t  ctrl;
  logic                 last;
  logic                 hold;

  modport seq (
    output valid, step,
    input  claim, ctrl, last, hold
  );

  modport dec (
    input  valid, step,
    output claim, ctrl, last, hold
  );

endinterface

// File: decode/integer_decoder.sv
module integer_decoder (
  input logic [31:0] instr,
  exec_if.dec        x
);

  rv32_isa_pkg::opcode_t opc;
  logic [2:0]            f3;
  logic                  alt;
  cpu_ctrl_pkg::ctrl_t   c;
  logic                  claim;
  logic                  last;
  logic                  hold;

  assign opc = rv32_isa_pkg::opcode_t'(instr[rv32_isa_pkg::OPC_LSB +: 7]);
  assign f3  = instr[rv32_isa_pkg::F3_LSB +: 3];
  assign alt = instr[rv32_isa_pkg::ALT_BIT];

  always_comb begin
    c     = cpu_ctrl_pkg::idle_word(instr);
    claim = 1'b0;
    last  = 1'b0;
    hold  = 1'b0;
    case (opc)
      rv32_isa_pkg::OPC_OP, rv32_isa_pkg::OPC_OP_IMM: begin
        claim = x.valid;
        if (opc == rv32_isa_pkg::OPC_OP_IMM) begin
          c.b_sel  = cpu_ctrl_pkg::B_IMM;
          c.format = cpu_ctrl_pkg::FMT_I;
        end
        case (f3)
          rv32_isa_pkg::F3_ADD: begin
            c.alu_op = (opc == rv32_isa_pkg::OPC_OP && alt) ? cpu_ctrl_pkg::ALU_SUB
                                                           : cpu_ctrl_pkg::ALU_ADD;
          end
          rv32_isa_pkg::F3_SLL: c.alu_op = cpu_ctrl_pkg::ALU_SLL;
          rv32_isa_pkg::F3_SLT: begin
            c.alu_op = cpu_ctrl_pkg::ALU_SUB;
            c.wd_sel = cpu_ctrl_pkg::WD_LT;
          end
          rv32_isa_pkg::F3_SLTU: begin
            c.alu_op = cpu_ctrl_pkg::ALU_SUB;
            c.wd_sel = cpu_ctrl_pkg::WD_LTU;
          end
          rv32_isa_pkg::F3_XOR: c.alu_op = cpu_ctrl_pkg::ALU_XOR;
          rv32_isa_pkg::F3_SR:  c.alu_op = alt ? cpu_ctrl_pkg::ALU_SRA : cpu_ctrl_pkg::ALU_SRL;
          rv32_isa_pkg::F3_OR:  c.alu_op = cpu_ctrl_pkg::ALU_OR;
          default:              c.alu_op = cpu_ctrl_pkg::ALU_AND;
        endcase
        c.rf_we = 1'b1;
        c       = cpu_ctrl_pkg::with_fetch(c);
        last    = 1'b1;
      end
      rv32_isa_pkg::OPC_LUI, rv32_isa_pkg::OPC_AUIPC: begin
        claim    = x.valid;
        c.format = cpu_ctrl_pkg::FMT_U;
        c.b_sel  = cpu_ctrl_pkg::B_IMM;
        if (opc == rv32_isa_pkg::OPC_AUIPC) begin
          c.a_sel  = cpu_ctrl_pkg::A_PC; // pc + imm
          c.alu_op = cpu_ctrl_pkg::ALU_ADD;
        end else begin
          c.alu_op = cpu_ctrl_pkg::ALU_PASS_B;
        end
        c.rf_we = 1'b1;
        c       = cpu_ctrl_pkg::with_fetch(c);
        last    = 1'b1;
      end
      rv32_isa_pkg::OPC_HALT: begin
        claim = x.valid;
        c     = cpu_ctrl_pkg::CTRL_IDLE;
        hold  = 1'b1; // parked for good
      end
      default: ;
    endcase
  end

  assign x.claim = claim;
  assign x.ctrl  = c;
  assign x.last  = last;
  assign x.hold  = hold;

endmodule

// File: decode/flow_decoder.sv
module flow_decoder (
  input logic [31:0] instr,
  input logic [31:0] temp,
  exec_if.dec        x
);

  rv32_isa_pkg::opcode_t opc;
  logic [2:0]            f3;
  logic                  taken;
  cpu_ctrl_pkg::ctrl_t   c;
  logic                  claim;
  logic                  last;

  assign opc = rv32_isa_pkg::opcode_t'(instr[rv32_isa_pkg::OPC_LSB +: 7]);
  assign f3  = instr[rv32_isa_pkg::F3_LSB +: 3];

  always_comb begin
    case (f3)
      rv32_isa_pkg::F3_BEQ:  taken = temp[rv32_isa_pkg::FLAG_ZERO];
      rv32_isa_pkg::F3_BNE:  taken = !temp[rv32_isa_pkg::FLAG_ZERO];
      rv32_isa_pkg::F3_BLT:  taken = temp[rv32_isa_pkg::FLAG_LT];
      rv32_isa_pkg::F3_BGE:  taken = !temp[rv32_isa_pkg::FLAG_LT];
      rv32_isa_pkg::F3_BLTU: taken = temp[rv32_isa_pkg::FLAG_LTU];
      rv32_isa_pkg::F3_BGEU: taken = !temp[rv32_isa_pkg::FLAG_LTU];
      default:               taken = 1'b0;
    endcase
  end

  always_comb begin
    c     = cpu_ctrl_pkg::idle_word(instr);
    claim = 1'b0;
    last  = 1'b0;
    case (opc)
      rv32_isa_pkg::OPC_JAL: begin
        claim    = x.valid;
        c.format = cpu_ctrl_pkg::FMT_J;
        c.a_sel  = cpu_ctrl_pkg::A_PC;
        c.b_sel  = cpu_ctrl_pkg::B_IMM;
        c.pc_sel = cpu_ctrl_pkg::PC_ALU;
        c.wd_sel = cpu_ctrl_pkg::WD_ALU4; // link = target + 4
        c.rf_we  = 1'b1;
        c        = cpu_ctrl_pkg::with_fetch(c);
        last     = 1'b1;
      end
      rv32_isa_pkg::OPC_JALR: begin
        claim = x.valid;
        case (x.step)
          2'd0: begin
            c.ra1     = 5'd0;
            c.alu_op  = cpu_ctrl_pkg::ALU_ONES; // lsb clear mask
            c.temp_we = 1'b1;
          end
          2'd1: begin
            c.b_sel = cpu_ctrl_pkg::B_IMM; // rd <= rs1 + imm
            c.rf_we = 1'b1;
          end
          default: begin
            c.ra1    = instr[rv32_isa_pkg::RD_LSB +: 5];
            c.b_sel  = cpu_ctrl_pkg::B_TEMP;
            c.alu_op = cpu_ctrl_pkg::ALU_AND;
            c.pc_sel = cpu_ctrl_pkg::PC_ALU;
            c.wd_sel = cpu_ctrl_pkg::WD_ALU4;
            c.rf_we  = 1'b1;
            c        = cpu_ctrl_pkg::with_fetch(c);
            last     = 1'b1;
          end
        endcase
      end
      rv32_isa_pkg::OPC_BRANCH: begin
        claim = x.valid;
        if (x.step == 2'd0) begin
          c.alu_op   = cpu_ctrl_pkg::ALU_SUB;
          c.temp_sel = 1'b1; // flags into temp
          c.temp_we  = 1'b1;
        end else begin
          if (taken) begin
            c.format = cpu_ctrl_pkg::FMT_B;
            c.a_sel  = cpu_ctrl_pkg::A_PC;
            c.b_sel  = cpu_ctrl_pkg::B_IMM;
            c.pc_sel = cpu_ctrl_pkg::PC_ALU;
          end
          c    = cpu_ctrl_pkg::with_fetch(c);
          last = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign x.claim = claim;
  assign x.ctrl  = c;
  assign x.last  = last;
  assign x.hold  = 1'b0;

endmodule

// File: decode/memory_decoder.sv
module memory_decoder (
  input logic [31:0] instr,
  input logic        memctrl_ready,
  exec_if.dec        x
);

  rv32_isa_pkg::opcode_t  opc;
  logic [2:0]             f3;
  logic                   is_load;
  logic                   is_store;
  logic                   kept;
  cpu_ctrl_pkg::mem_cmd_t cmd;
  cpu_ctrl_pkg::ctrl_t    access;
  cpu_ctrl_pkg::ctrl_t    c;
  logic                   claim;
  logic                   last;
  logic                   hold;

  assign opc      = rv32_isa_pkg::opcode_t'(instr[rv32_isa_pkg::OPC_LSB +: 7]);
  assign f3       = instr[rv32_isa_pkg::F3_LSB +: 3];
  assign is_load  = (opc == rv32_isa_pkg::OPC_LOAD);
  assign is_store = (opc == rv32_isa_pkg::OPC_STORE);

  always_comb begin
    kept = 1'b1;
    cmd  = cpu_ctrl_pkg::MEM_RW;
    if (is_load) begin
      case (f3)
        rv32_isa_pkg::F3_LW:  cmd = cpu_ctrl_pkg::MEM_RW;
        rv32_isa_pkg::F3_LBU: cmd = cpu_ctrl_pkg::MEM_RB;
        rv32_isa_pkg::F3_LHU: cmd = cpu_ctrl_pkg::MEM_RH;
        default:              kept = 1'b0; // signed byte/half left unclaimed
      endcase
    end else begin
      case (f3)
        rv32_isa_pkg::F3_SB: cmd = cpu_ctrl_pkg::MEM_WB;
        rv32_isa_pkg::F3_SH: cmd = cpu_ctrl_pkg::MEM_WH;
        rv32_isa_pkg::F3_SW: cmd = cpu_ctrl_pkg::MEM_WW;
        default:             kept = 1'b0;
      endcase
    end
  end

  // rs1 + imm routed to the memory address through the pc mux
  always_comb begin
    access            = cpu_ctrl_pkg::idle_word(instr);
    access.format     = is_store ? cpu_ctrl_pkg::FMT_S : cpu_ctrl_pkg::FMT_I;
    access.b_sel      = cpu_ctrl_pkg::B_IMM;
    access.pc_sel     = cpu_ctrl_pkg::PC_ALU;
    access.mem_cmd    = cmd;
    access.memctrl_en = 1'b1;
  end

  always_comb begin
    c     = cpu_ctrl_pkg::idle_word(instr);
    claim = 1'b0;
    last  = 1'b0;
    hold  = 1'b0;
    if ((is_load || is_store) && kept) begin
      claim = x.valid;
      if (is_load && x.step == 2'd0) begin
        c = access;
      end else if (is_store && x.step == 2'd0) begin
        c.alu_op  = cpu_ctrl_pkg::ALU_PASS_B; // temp <= rs2
        c.temp_we = 1'b1;
      end else if (is_store && x.step == 2'd1) begin
        c = access;
      end else if (memctrl_ready) begin
        if (is_load) begin
          c.wd_sel = cpu_ctrl_pkg::WD_MEM;
          c.rf_we  = 1'b1;
        end
        c    = cpu_ctrl_pkg::with_fetch(c);
        last = 1'b1;
      end else begin
        c    = access; // wait on controller
        hold = 1'b1;
      end
    end
  end

  assign x.claim = claim;
  assign x.ctrl  = c;
  assign x.last  = last;
  assign x.hold  = hold;

endmodule

// File: hdl/control_sequencer.sv
module control_sequencer (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                memctrl_ready,
  exec_if.seq                 int_x,
  exec_if.seq                 flow_x,
  exec_if.seq                 mem_x,
  output cpu_ctrl_pkg::ctrl_t ctrl,
  output logic                instr_we
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_FETCH,
    PH_EXEC
  } phase_t;

  phase_t              phase;
  rv32_isa_pkg::step_t step;
  logic                exec;
  logic                last;
  logic                hold;

  assign exec = (phase == PH_EXEC);

  assign int_x.valid  = exec;
  assign int_x.step   = step;
  assign flow_x.valid = exec;
  assign flow_x.step  = step;
  assign mem_x.valid  = exec;
  assign mem_x.step   = step;

  always_comb begin
    ctrl     = cpu_ctrl_pkg::CTRL_IDLE;
    instr_we = 1'b0;
    last     = 1'b0;
    hold     = 1'b0;
    case (phase)
      PH_IDLE: if (start) begin
        ctrl        = cpu_ctrl_pkg::with_fetch(cpu_ctrl_pkg::CTRL_IDLE);
        ctrl.pc_sel = cpu_ctrl_pkg::PC_INIT;
      end
      PH_FETCH: begin
        ctrl.memctrl_en = 1'b1; // keep request up until ready
        instr_we        = memctrl_ready;
      end
      default: begin
        if (int_x.claim) begin
          ctrl = int_x.ctrl;
          last = int_x.last;
          hold = int_x.hold;
        end else if (flow_x.claim) begin
          ctrl = flow_x.ctrl;
          last = flow_x.last;
          hold = flow_x.hold;
        end else if (mem_x.claim) begin
          ctrl = mem_x.ctrl;
          last = mem_x.last;
          hold = mem_x.hold;
        end else begin
          ctrl = cpu_ctrl_pkg::with_fetch(cpu_ctrl_pkg::CTRL_IDLE); // skip unknown
          last = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_IDLE;
      step  <= '0;
    end else begin
      case (phase)
        PH_IDLE: if (start) phase <= PH_FETCH;
        PH_FETCH: if (memctrl_ready) begin
          phase <= PH_EXEC;
          step  <= '0;
        end
        default: if (last) begin
          phase <= PH_FETCH;
        end else if (!hold) begin
          step <= step + 2'd1;
        end
      endcase
    end
  end

endmodule

// File: hdl/cpu_control.sv
module cpu_control (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   memctrl_ready,
  input  logic [31:0]            instr,
  input  logic [31:0]            temp,
  output logic                   instr_we,
  output logic                   rf_we,
  output logic                   rf_pc_we,
  output logic                   temp_we,
  output logic                   temp_sel,
  output logic                   memctrl_en,
  output cpu_ctrl_pkg::mem_cmd_t memctrl_cmd,
  output cpu_ctrl_pkg::pc_sel_t  pc_sel,
  output cpu_ctrl_pkg::opnd_a_t  a_sel,
  output cpu_ctrl_pkg::opnd_b_t  b_sel,
  output cpu_ctrl_pkg::wd_sel_t  wd_sel,
  output cpu_ctrl_pkg::imm_fmt_t format,
  output cpu_ctrl_pkg::alu_op_t  alu_op,
  output logic [4:0]             rf_ra1,
  output logic [4:0]             rf_ra2,
  output logic [4:0]             rf_wa
);

  cpu_ctrl_pkg::ctrl_t ctrl;

  exec_if int_x ();
  exec_if flow_x ();
  exec_if mem_x ();

  control_sequencer i_seq (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .memctrl_ready (memctrl_ready),
    .int_x         (int_x),
    .flow_x        (flow_x),
    .mem_x         (mem_x),
    .ctrl          (ctrl),
    .instr_we      (instr_we)
  );

  integer_decoder i_int (.instr(instr), .x(int_x));

  flow_decoder i_flow (.instr(instr), .temp(temp), .x(flow_x));

  memory_decoder i_mem (.instr(instr), .memctrl_ready(memctrl_ready), .x(mem_x));

  assign rf_we       = ctrl.rf_we;
  assign rf_pc_we    = ctrl.rf_pc_we;
  assign temp_we     = ctrl.temp_we;
  assign temp_sel    = ctrl.temp_sel;
  assign memctrl_en  = ctrl.memctrl_en;
  assign memctrl_cmd = ctrl.mem_cmd;
  assign pc_sel      = ctrl.pc_sel;
  assign a_sel       = ctrl.a_sel;
  assign b_sel       = ctrl.b_sel;
  assign wd_sel      = ctrl.wd_sel;
  assign format      = ctrl.format;
  assign alu_op      = ctrl.alu_op;
  assign rf_ra1      = ctrl.ra1;
  assign rf_ra2      = ctrl.ra2;
  assign rf_wa       = ctrl.wa;

endmodule

// File: testbench/cpu_control_tb.sv
module cpu_control_tb;

  localparam int NUM_TESTS = 56;

  logic clk;
  logic rst;
  logic start;
  logic memctrl_ready;
  logic [31:0] instr_r;
  logic [31:0] temp;

  logic instr_we;
  logic rf_we;
  logic rf_pc_we;
  logic temp_we;
  logic temp_sel;
  logic memctrl_en;
  cpu_ctrl_pkg::mem_cmd_t memctrl_cmd;
  cpu_ctrl_pkg::pc_sel_t pc_sel;
  cpu_ctrl_pkg::opnd_a_t a_sel;
  cpu_ctrl_pkg::opnd_b_t b_sel;
  cpu_ctrl_pkg::wd_sel_t wd_sel;
  cpu_ctrl_pkg::imm_fmt_t format;
  cpu_ctrl_pkg::alu_op_t alu_op;
  logic [4:0] rf_ra1;
  logic [4:0] rf_ra2;
  logic [4:0] rf_wa;

  integer seed = 32'h5d70;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int done_cnt = 0;
  int exec_cycles = 0;
  int stalls = 0;
  int mem_wait = 1;
  logic exec_on = 1'b0;
  logic [1:0] step_m = 2'd0;
  logic ir_load = 1'b0;
  logic consume = 1'b0;
  logic tick = 1'b0;
  logic [31:0] next_word = 32'h0;
  string cur_name = "boot";

  cpu_control i_dut (
    .clk(clk), .rst(rst), .start(start), .memctrl_ready(memctrl_ready),
    .instr(instr_r), .temp(temp), .instr_we(instr_we), .rf_we(rf_we),
    .rf_pc_we(rf_pc_we), .temp_we(temp_we), .temp_sel(temp_sel),
    .memctrl_en(memctrl_en), .memctrl_cmd(memctrl_cmd), .pc_sel(pc_sel),
    .a_sel(a_sel), .b_sel(b_sel), .wd_sel(wd_sel), .format(format),
    .alu_op(alu_op), .rf_ra1(rf_ra1), .rf_ra2(rf_ra2), .rf_wa(rf_wa)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic cpu_ctrl_pkg::ctrl_t act_ctrl();
    cpu_ctrl_pkg::ctrl_t c;
    c.rf_we      = rf_we;
    c.rf_pc_we   = rf_pc_we;
    c.temp_we    = temp_we;
    c.temp_sel   = temp_sel;
    c.memctrl_en = memctrl_en;
    c.pc_sel     = pc_sel;
    c.a_sel      = a_sel;
    c.b_sel      = b_sel;
    c.wd_sel     = wd_sel;
    c.format     = format;
    c.alu_op     = alu_op;
    c.mem_cmd    = memctrl_cmd;
    c.ra1        = rf_ra1;
    c.ra2        = rf_ra2;
    c.wa         = rf_wa;
    return c;
  endfunction

  // expected control word, last and hold for one execute cycle
  function automatic cpu_ctrl_pkg::ctrl_t expect_ctrl(input logic [31:0] ins,
      input logic [31:0] t, input logic [1:0] st, input logic rdy,
      output logic lst, output logic hld);
    cpu_ctrl_pkg::ctrl_t c;
    cpu_ctrl_pkg::ctrl_t acc;
    logic [6:0] opc;
    logic [2:0] f3;
    logic b30;
    logic tk;
    logic fin;
    opc = ins[6:0];
    f3  = ins[14:12];
    b30 = ins[30];
    lst = 1'b0;
    hld = 1'b0;
    fin = 1'b0;
    c = cpu_ctrl_pkg::CTRL_IDLE;
    c.ra1 = ins[19:15];
    c.ra2 = ins[24:20];
    c.wa  = ins[11:7];
    acc = c; // memory access word
    acc.b_sel = cpu_ctrl_pkg::B_IMM;
    acc.pc_sel = cpu_ctrl_pkg::PC_ALU;
    acc.memctrl_en = 1'b1;
    acc.format = (opc == rv32_isa_pkg::OPC_STORE) ? cpu_ctrl_pkg::FMT_S : cpu_ctrl_pkg::FMT_I;
    case (f3)
      3'd0: acc.mem_cmd = (opc == rv32_isa_pkg::OPC_STORE) ? cpu_ctrl_pkg::MEM_WB
                                                           : cpu_ctrl_pkg::MEM_RW;
      3'd1: acc.mem_cmd = cpu_ctrl_pkg::MEM_WH;
      3'd2: acc.mem_cmd = (opc == rv32_isa_pkg::OPC_STORE) ? cpu_ctrl_pkg::MEM_WW
                                                           : cpu_ctrl_pkg::MEM_RW;
      3'd4: acc.mem_cmd = cpu_ctrl_pkg::MEM_RB;
      default: acc.mem_cmd = cpu_ctrl_pkg::MEM_RH;
    endcase
    case (f3)
      3'd0: tk = t[0];
      3'd1: tk = !t[0];
      3'd4: tk = t[1];
      3'd5: tk = !t[1];
      3'd6: tk = t[2];
      default: tk = !t[2];
    endcase
    if (opc == rv32_isa_pkg::OPC_OP || opc == rv32_isa_pkg::OPC_OP_IMM) begin
      if (opc == rv32_isa_pkg::OPC_OP_IMM) c.b_sel = cpu_ctrl_pkg::B_IMM;
      case (f3)
        3'd0: c.alu_op = (opc == rv32_isa_pkg::OPC_OP && b30) ? cpu_ctrl_pkg::ALU_SUB
                                                             : cpu_ctrl_pkg::ALU_ADD;
        3'd1: c.alu_op = cpu_ctrl_pkg::ALU_SLL;
        3'd2: begin
          c.alu_op = cpu_ctrl_pkg::ALU_SUB;
          c.wd_sel = cpu_ctrl_pkg::WD_LT;
        end
        3'd3: begin
          c.alu_op = cpu_ctrl_pkg::ALU_SUB;
          c.wd_sel = cpu_ctrl_pkg::WD_LTU;
        end
        3'd4: c.alu_op = cpu_ctrl_pkg::ALU_XOR;
        3'd5: c.alu_op = b30 ? cpu_ctrl_pkg::ALU_SRA : cpu_ctrl_pkg::ALU_SRL;
        3'd6: c.alu_op = cpu_ctrl_pkg::ALU_OR;
        default: c.alu_op = cpu_ctrl_pkg::ALU_AND;
      endcase
      c.rf_we = 1'b1;
      fin = 1'b1;
    end else if (opc == rv32_isa_pkg::OPC_LUI || opc == rv32_isa_pkg::OPC_AUIPC) begin
      c.format = cpu_ctrl_pkg::FMT_U;
      c.b_sel = cpu_ctrl_pkg::B_IMM;
      c.alu_op = cpu_ctrl_pkg::ALU_PASS_B;
      if (opc == rv32_isa_pkg::OPC_AUIPC) begin
        c.a_sel = cpu_ctrl_pkg::A_PC;
        c.alu_op = cpu_ctrl_pkg::ALU_ADD;
      end
      c.rf_we = 1'b1;
      fin = 1'b1;
    end else if (opc == rv32_isa_pkg::OPC_HALT) begin
      c = cpu_ctrl_pkg::CTRL_IDLE;
      hld = 1'b1;
    end else if (opc == rv32_isa_pkg::OPC_JAL) begin
      c.format = cpu_ctrl_pkg::FMT_J;
      c.a_sel = cpu_ctrl_pkg::A_PC;
      c.b_sel = cpu_ctrl_pkg::B_IMM;
      c.pc_sel = cpu_ctrl_pkg::PC_ALU;
      c.wd_sel = cpu_ctrl_pkg::WD_ALU4;
      c.rf_we = 1'b1;
      fin = 1'b1;
    end else if (opc == rv32_isa_pkg::OPC_JALR) begin
      if (st == 2'd0) begin
        c.ra1 = 5'd0;
        c.alu_op = cpu_ctrl_pkg::ALU_ONES;
        c.temp_we = 1'b1;
      end else if (st == 2'd1) begin
        c.b_sel = cpu_ctrl_pkg::B_IMM;
        c.rf_we = 1'b1;
      end else begin
        c.ra1 = ins[11:7];
        c.b_sel = cpu_ctrl_pkg::B_TEMP;
        c.alu_op = cpu_ctrl_pkg::ALU_AND;
        c.pc_sel = cpu_ctrl_pkg::PC_ALU;
        c.wd_sel = cpu_ctrl_pkg::WD_ALU4;
        c.rf_we = 1'b1;
        fin = 1'b1;
      end
    end else if (opc == rv32_isa_pkg::OPC_BRANCH) begin
      if (st == 2'd0) begin
        c.alu_op = cpu_ctrl_pkg::ALU_SUB;
        c.temp_sel = 1'b1;
        c.temp_we = 1'b1;
      end else begin
        if (tk) begin
          c.format = cpu_ctrl_pkg::FMT_B;
          c.a_sel = cpu_ctrl_pkg::A_PC;
          c.b_sel = cpu_ctrl_pkg::B_IMM;
          c.pc_sel = cpu_ctrl_pkg::PC_ALU;
        end
        fin = 1'b1;
      end
    end else if (opc == rv32_isa_pkg::OPC_LOAD && (f3 == 2 || f3 == 4 || f3 == 5)) begin
      if (st == 2'd0) begin
        c = acc;
      end else if (rdy) begin
        c.wd_sel = cpu_ctrl_pkg::WD_MEM;
        c.rf_we = 1'b1;
        fin = 1'b1;
      end else begin
        c = acc;
        hld = 1'b1;
      end
    end else if (opc == rv32_isa_pkg::OPC_STORE && f3 <= 3'd2) begin
      if (st == 2'd0) begin
        c.alu_op = cpu_ctrl_pkg::ALU_PASS_B;
        c.temp_we = 1'b1;
      end else if (st == 2'd1) begin
        c = acc;
      end else if (rdy) begin
        fin = 1'b1;
      end else begin
        c = acc;
        hld = 1'b1;
      end
    end else begin
      c = cpu_ctrl_pkg::CTRL_IDLE; // skipped opcode
      fin = 1'b1;
    end
    if (fin) begin
      c.rf_pc_we = 1'b1;
      c.memctrl_en = 1'b1;
      c.mem_cmd = cpu_ctrl_pkg::MEM_RW;
      lst = 1'b1;
    end
    return c;
  endfunction

  function automatic int base_cycles(input logic [31:0] ins);
    logic [2:0] f3;
    f3 = ins[14:12];
    case (ins[6:0])
      rv32_isa_pkg::OPC_BRANCH: return 2;
      rv32_isa_pkg::OPC_JALR:   return 3;
      rv32_isa_pkg::OPC_LOAD:   return (f3 == 2 || f3 == 4 || f3 == 5) ? 2 : 1;
      rv32_isa_pkg::OPC_STORE:  return (f3 <= 3'd2) ? 3 : 1;
      default:                  return 1;
    endcase
  endfunction

  task automatic check_ctrl(input string name, input cpu_ctrl_pkg::ctrl_t exp,
      input cpu_ctrl_pkg::ctrl_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_alu(input string name, input cpu_ctrl_pkg::alu_op_t exp,
      input cpu_ctrl_pkg::alu_op_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected alu_op %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_steps(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d cycles, actual %0d", name, exp, act);
    end
  endtask

  // compare process sampling at the falling edge
  always @(negedge clk) begin
    cpu_ctrl_pkg::ctrl_t exp_c;
    logic exp_last;
    logic exp_hold;
    consume = memctrl_en && memctrl_ready;
    tick    = memctrl_en && !memctrl_ready;
    ir_load = instr_we;
    if (instr_we && (!memctrl_ready || exec_on)) begin
      errors++;
      $display("instr_we was asserted outside a fetch cycle with memctrl_ready in %s",
               cur_name);
    end
    if (exec_on && !rst) begin
      exp_c = expect_ctrl(instr_r, temp, step_m, memctrl_ready, exp_last, exp_hold);
      check_ctrl(cur_name, exp_c, act_ctrl());
      check_alu(cur_name, exp_c.alu_op, alu_op);
      exec_cycles++;
      if (exp_hold) stalls++;
      if (rf_pc_we || exp_last) begin
        exec_on = 1'b0;
        check_steps(cur_name, base_cycles(instr_r) + stalls, exec_cycles);
        done_cnt++;
      end else if (!exp_hold) begin
        step_m++;
      end
    end
    if (instr_we) begin
      exec_on     = 1'b1;
      step_m      = 2'd0;
      exec_cycles = 0;
      stalls      = 0;
    end
  end

  // instruction register and memory ready model
  always @(posedge clk) begin
    int d;
    if (ir_load) instr_r <= next_word;
    if (consume) begin
      d = $unsigned($random(seed)) % 4;
      mem_wait <= d;
      memctrl_ready <= (d == 0);
    end else if (tick) begin
      mem_wait <= mem_wait - 1;
      memctrl_ready <= (mem_wait == 1);
    end
  end

  task automatic run_test(input string name, input logic [31:0] word, input logic [31:0] t);
    int target;
    int err0;
    target = done_cnt + 1;
    err0 = errors;
    cur_name = name;
    next_word = word;
    @(posedge clk);
    temp <= t;
    wait (done_cnt >= target);
    tests++;
    $display("%-12s %s", name, (errors == err0) ? "pass" : "fail");
  endtask

  initial begin
    #(NUM_TESTS * 12 * 40);
    $display("watchdog expired after %0d tests", tests);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    cpu_ctrl_pkg::ctrl_t boot_c;
    logic [31:0] w;
    logic [2:0] br_f3 [6];
    logic [2:0] mem_f3 [6];
    int idx;
    int pcw;
    int halt_err;
    br_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    mem_f3 = '{3'd2, 3'd4, 3'd5, 3'd0, 3'd1, 3'd2}; // loads then stores
    rst = 1'b1;
    start = 1'b0;
    memctrl_ready = 1'b0;
    instr_r = 32'h0;
    temp = 32'h0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_ctrl("reset", cpu_ctrl_pkg::CTRL_IDLE, act_ctrl());
    check_steps("reset_instr_we", 0, int'(instr_we));
    next_word = 32'h00500093; // addi x1, x0, 5
    @(posedge clk);
    start <= 1'b1;
    @(negedge clk);
    boot_c = cpu_ctrl_pkg::CTRL_IDLE;
    boot_c.pc_sel = cpu_ctrl_pkg::PC_INIT;
    boot_c.rf_pc_we = 1'b1;
    boot_c.memctrl_en = 1'b1;
    check_ctrl("boot", boot_c, act_ctrl());
    @(posedge clk);
    start <= 1'b0;
    wait (done_cnt >= 1);
    tests++;
    $display("%-12s %s", "boot", (errors == 0) ? "pass" : "fail");
    for (int i = 0; i < 20; i++) begin
      w = $random(seed);
      w[6:0] = (i % 2) ? rv32_isa_pkg::OPC_OP : rv32_isa_pkg::OPC_OP_IMM;
      run_test($sformatf("alu_%0d", i), w, 32'h0);
    end
    for (int i = 0; i < 12; i++) begin
      w = $random(seed);
      idx = $unsigned($random(seed)) % 6;
      w[6:0] = rv32_isa_pkg::OPC_BRANCH;
      w[14:12] = br_f3[idx];
      run_test($sformatf("branch_%0d", i), w, $random(seed) & 32'h7);
    end
    for (int i = 0; i < 16; i++) begin
      w = $random(seed);
      idx = $unsigned($random(seed)) % 6;
      w[6:0] = (idx < 3) ? rv32_isa_pkg::OPC_LOAD : rv32_isa_pkg::OPC_STORE;
      w[14:12] = mem_f3[idx];
      run_test($sformatf("mem_%0d", i), w, 32'h0);
    end
    run_test("jal", 32'h008000ef, 32'h0);
    run_test("jalr", 32'h004080e7, 32'h0);
    run_test("lui", 32'h123450b7, 32'h0);
    run_test("auipc", 32'h00001117, 32'h0);
    run_test("unknown", 32'h0000000f, 32'h0);
    run_test("lb_skip", 32'h00008083, 32'h0);
    halt_err = errors;
    cur_name = "halt";
    next_word = 32'h0;
    wait (exec_on);
    pcw = 0;
    repeat (20) begin
      @(negedge clk);
      if (rf_pc_we) pcw++;
    end
    check_steps("halt_pc_we", 0, pcw);
    tests++;
    $display("%-12s %s", "halt", (errors == halt_err) ? "pass" : "fail");
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
common/rv32_isa_pkg.sv
common/cpu_ctrl_pkg.sv
common/exec_if.sv
decode/integer_decoder.sv
decode/flow_decoder.sv
decode/memory_decoder.sv
hdl/control_sequencer.sv
hdl/cpu_control.sv
testbench/cpu_control_tb.sv

// File: run.sh
#!/bin/sh
# compile and run with Verilator, then look for the fail message in the log
verilator --binary --timing -f build.f --top-module cpu_control_tb -o cpu_control_sim \
  > sim.log 2>&1 &&
./obj_dir/cpu_control_sim >> sim.log 2>&1 ||
{ echo "build or simulation error, see sim.log"; exit 1; }
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; } || exit 0
